/* Bender.yml */
package:
  name: raycast

sources:
  - logic/rc_pkg.sv
  - logic/shape_mem_if.sv
  - logic/shape_store.sv
  - logic/shape_loader.sv
  - logic/sphere_test.sv
  - logic/nearest_hit_sweep.sv
  - logic/raycast_top.sv
  - target: test
    files:
      - dv/tb_raycast.sv

/* all.f */
logic/rc_pkg.sv
logic/shape_mem_if.sv
logic/shape_store.sv
logic/shape_loader.sv
logic/sphere_test.sv
logic/nearest_hit_sweep.sv
logic/raycast_top.sv
dv/tb_raycast.sv

/* dv/raycast_vectors.txt */
# load: L addr type(0 off, 1 sphere) cx cy cz radius_sq
# ray:  R sx sy sz dx dy dz exp_hit exp_addr exp_key   (decimal)

# table empty after reset
R 0 0 0 1 0 0 0 0 0
# single sphere at x=100, radius 20
L 0 1 100 0 0 400
R 0 0 0 1 0 0 1 0 9600
# pointing away, then sideways
R 0 0 0 -1 0 0 0 0 0
R 0 0 0 0 1 0 0 0 0
# spheres in a row along +x
L 1 1 50 0 0 100
L 2 1 200 0 0 400
R 0 0 0 1 0 0 1 1 2400
R 0 0 0 2 0 0 1 1 2400
# offset ray misses all three
R 0 30 0 1 0 0 0 0 0
# source inside sphere 0, negative key
R 95 0 0 1 0 0 1 0 -375
# copy of entry 1 gives equal keys, tangent hit on entry 1
L 5 1 50 0 0 100
R 0 10 0 1 0 0 1 1 2500
# diagonal ray
L 3 1 30 40 0 100
R 0 0 0 3 4 0 1 3 2400
# entry 1 switched off, its copy takes over
L 1 0 0 0 0 0
R 0 0 0 1 0 0 1 5 2400
R 0 10 0 1 0 0 1 5 2500
# extra spheres for the random rays
L 4 1 0 0 0 10000
L 6 1 -100 50 20 2500
L 7 1 0 -80 60 900

/* dv/tb_raycast.sv */
`timescale 1ns/1ps

module tb_raycast;

    localparam int ACK_TIMEOUT = 200;

    logic clk;
    logic rst;
    logic load_req_i;
    logic load_ack_o;
    logic [rc_pkg::ADDR_W-1:0] load_addr_i;
    rc_pkg::shape_t load_shape_i;
    logic ray_req_i;
    logic ray_ack_o;
    rc_pkg::vec3_t ray_src_i;
    rc_pkg::vec3_t ray_dir_i;
    logic hit_o;
    logic [rc_pkg::ADDR_W-1:0] hit_addr_o;
    rc_pkg::key_t hit_key_o;

    int checks;
    int errors;
    int timeouts;
    logic [31:0] rng;

    // model copy of the shape table
    bit tab_on [rc_pkg::NUM_SHAPES];
    longint tab_cx [rc_pkg::NUM_SHAPES];
    longint tab_cy [rc_pkg::NUM_SHAPES];
    longint tab_cz [rc_pkg::NUM_SHAPES];
    longint tab_r2 [rc_pkg::NUM_SHAPES];

    raycast_top uut (
        .clk(clk),
        .rst(rst),
        .load_req_i(load_req_i),
        .load_ack_o(load_ack_o),
        .load_addr_i(load_addr_i),
        .load_shape_i(load_shape_i),
        .ray_req_i(ray_req_i),
        .ray_ack_o(ray_ack_o),
        .ray_src_i(ray_src_i),
        .ray_dir_i(ray_dir_i),
        .hit_o(hit_o),
        .hit_addr_o(hit_addr_o),
        .hit_key_o(hit_key_o)
    );

    always #2 clk = ~clk;

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // value in lo .. lo+span-1
    function automatic int rand_between(input int lo, input int span);
        rng = xorshift32(rng);
        return lo + int'(rng % span);
    endfunction

    function automatic rc_pkg::vec3_t make_vec(input int x, input int y, input int z);
        rc_pkg::vec3_t v;
        v.x = rc_pkg::coord_t'(x);
        v.y = rc_pkg::coord_t'(y);
        v.z = rc_pkg::coord_t'(z);
        return v;
    endfunction

    task automatic wait_load_ack(input logic level, input string what, output bit ok);
        int cycles;
        cycles = 0;
        while (load_ack_o !== level && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (load_ack_o === level);
        if (!ok) begin
            $display("ERROR: timed out after %0d cycles waiting for %s", cycles, what);
            timeouts++;
        end
    endtask

    task automatic wait_ray_ack(input logic level, input string what, output bit ok);
        int cycles;
        cycles = 0;
        while (ray_ack_o !== level && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (ray_ack_o === level);
        if (!ok) begin
            $display("ERROR: timed out after %0d cycles waiting for %s", cycles, what);
            timeouts++;
        end
    endtask

    // nearest hitting sphere wins and the lower address breaks a tie
    task automatic predict_nearest(input rc_pkg::vec3_t src, input rc_pkg::vec3_t dir,
                                   output logic p_hit, output int p_addr,
                                   output longint p_key);
        longint ox;
        longint oy;
        longint oz;
        longint dx;
        longint dy;
        longint dz;
        longint a;
        longint b;
        longint c;
        p_hit = 1'b0;
        p_addr = 0;
        p_key = 0;
        dx = dir.x;
        dy = dir.y;
        dz = dir.z;
        for (int i = 0; i < rc_pkg::NUM_SHAPES; i++) begin
            ox = src.x;
            oy = src.y;
            oz = src.z;
            ox = ox - tab_cx[i];
            oy = oy - tab_cy[i];
            oz = oz - tab_cz[i];
            a = dx * dx + dy * dy + dz * dz;
            b = ox * dx + oy * dy + oz * dz;
            c = ox * ox + oy * oy + oz * oz - tab_r2[i];
            if (tab_on[i] && b < 0 && b * b - a * c >= 0) begin
                if (!p_hit || c < p_key) begin
                    p_hit = 1'b1;
                    p_addr = i;
                    p_key = c;
                end
            end
        end
    endtask

    task automatic load_shape(input int addr, input int kind, input int cx, input int cy,
                              input int cz, input int r2, output bit ok);
        @(posedge clk);
        #1;
        load_addr_i = rc_pkg::ADDR_W'(addr);
        load_shape_i.shape_type = (kind != 0) ? rc_pkg::shape_sphere : rc_pkg::shape_off;
        load_shape_i.centre = make_vec(cx, cy, cz);
        load_shape_i.radius_sq = rc_pkg::DOT_W'(r2);
        load_req_i = 1'b1;
        wait_load_ack(1'b1, "load_ack_o to rise", ok);
        if (ok) begin
            // ack stays up for as long as the request is held
            @(posedge clk);
            #1;
            check_value("load_ack_o", load_ack_o, 1'b1);
        end
        load_req_i = 1'b0;
        if (ok) begin
            wait_load_ack(1'b0, "load_ack_o to fall", ok);
        end
        tab_on[addr] = (kind != 0);
        tab_cx[addr] = cx;
        tab_cy[addr] = cy;
        tab_cz[addr] = cz;
        tab_r2[addr] = r2;
    endtask

    task automatic run_ray(input rc_pkg::vec3_t src, input rc_pkg::vec3_t dir,
                           input int hold, input bit from_file, input int e_hit,
                           input int e_addr, input int e_key, output bit ok);
        logic p_hit;
        int p_addr;
        longint p_key;
        logic got_hit;
        logic [rc_pkg::ADDR_W-1:0] got_addr;
        rc_pkg::key_t got_key;
        predict_nearest(src, dir, p_hit, p_addr, p_key);
        @(posedge clk);
        #1;
        ray_src_i = src;
        ray_dir_i = dir;
        ray_req_i = 1'b1;
        wait_ray_ack(1'b1, "ray_ack_o to rise", ok);
        if (ok) begin
            got_hit = hit_o;
            got_addr = hit_addr_o;
            got_key = hit_key_o;
            check_value("hit_o", hit_o, p_hit);
            check_value("hit_addr_o", hit_addr_o, p_addr);
            check_value("hit_key_o", hit_key_o, rc_pkg::key_t'(p_key));
            if (from_file) begin
                check_value("hit_o (vectors)", hit_o, e_hit);
                check_value("hit_addr_o (vectors)", hit_addr_o, e_addr);
                check_value("hit_key_o (vectors)", hit_key_o, rc_pkg::key_t'(e_key));
            end
            // results frozen while the request is held
            repeat (hold) begin
                @(posedge clk);
                #1;
                check_value("ray_ack_o", ray_ack_o, 1'b1);
                check_value("hit_o held", hit_o, got_hit);
                check_value("hit_addr_o held", hit_addr_o, got_addr);
                check_value("hit_key_o held", hit_key_o, got_key);
            end
        end
        ray_req_i = 1'b0;
        if (ok) begin
            wait_ray_ack(1'b0, "ray_ack_o to fall", ok);
        end
    endtask

    initial begin
        int fd;
        int rc;
        int n;
        int v [9];
        string line;
        rc_pkg::vec3_t src;
        rc_pkg::vec3_t dir;
        bit ok;
        clk = 1'b0;
        rst = 1'b1;
        load_req_i = 1'b0;
        load_addr_i = '0;
        load_shape_i = '0;
        ray_req_i = 1'b0;
        ray_src_i = '0;
        ray_dir_i = '0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        rng = 32'd37;
        ok = 1'b1;
        for (int i = 0; i < rc_pkg::NUM_SHAPES; i++) begin
            tab_on[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("dv/raycast_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open dv/raycast_vectors.txt");
            errors++;
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc == 0 || line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if (line[0] == "L") begin
                    n = $sscanf(line, "L %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4],
                                v[5]);
                    if (n != 6) begin
                        $display("ERROR: malformed load line in vector file: %s", line);
                        errors++;
                    end else begin
                        load_shape(v[0], v[1], v[2], v[3], v[4], v[5], ok);
                    end
                end else if (line[0] == "R") begin
                    n = $sscanf(line, "R %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                                v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n != 9) begin
                        $display("ERROR: malformed ray line in vector file: %s", line);
                        errors++;
                    end else begin
                        src = make_vec(v[0], v[1], v[2]);
                        dir = make_vec(v[3], v[4], v[5]);
                        run_ray(src, dir, 2, 1'b1, v[6], v[7], v[8], ok);
                    end
                end else begin
                    $display("ERROR: unknown line in vector file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end

        // 24 random rays against whatever the file left loaded
        for (int k = 0; k < 24 && ok; k++) begin
            src = make_vec(rand_between(-128, 256), rand_between(-128, 256),
                           rand_between(-128, 256));
            dir = make_vec(rand_between(-16, 32), rand_between(-16, 32),
                           rand_between(-16, 32));
            run_ray(src, dir, rand_between(0, 6), 1'b0, 0, 0, 0, ok);
        end

        finish_run();
    end

endmodule

/* logic/nearest_hit_sweep.sv */
`timescale 1ns/1ps

module nearest_hit_sweep (
    input logic clk,
    input logic rst,
    input logic ray_req_i,
    output logic ray_ack_o,
    input rc_pkg::vec3_t ray_src_i,
    input rc_pkg::vec3_t ray_dir_i,
    output logic hit_o,
    output logic [rc_pkg::ADDR_W-1:0] hit_addr_o,
    output rc_pkg::key_t hit_key_o,
    shape_mem_if.requester mem
);

    localparam logic [rc_pkg::ADDR_W-1:0] LAST_ADDR = rc_pkg::ADDR_W'(rc_pkg::NUM_SHAPES - 1);

    rc_pkg::sweep_state_e state;
    rc_pkg::vec3_t src_q;
    rc_pkg::vec3_t dir_q;
    logic [rc_pkg::ADDR_W-1:0] fetch_addr;
    logic req_q;

    logic feed_valid;
    logic res_valid;
    logic [rc_pkg::ADDR_W-1:0] res_addr;
    logic res_hit;
    rc_pkg::key_t res_key;

    // best result so far
    logic best_valid;
    logic [rc_pkg::ADDR_W-1:0] best_addr;
    rc_pkg::key_t best_key;

    // shape goes straight into the test while the read ack is up
    assign feed_valid = (state == rc_pkg::sweep_fetch) && req_q && mem.ack;

    sphere_test u_test (
        .clk(clk),
        .rst(rst),
        .valid_i(feed_valid),
        .addr_i(fetch_addr),
        .src_i(src_q),
        .dir_i(dir_q),
        .shape_i(mem.rdata),
        .valid_o(res_valid),
        .addr_o(res_addr),
        .hit_o(res_hit),
        .key_o(res_key)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rc_pkg::sweep_idle;
            fetch_addr <= '0;
            req_q <= 1'b0;
            ray_ack_o <= 1'b0;
        end else begin
            case (state)
                rc_pkg::sweep_idle: begin
                    if (ray_req_i) begin
                        fetch_addr <= '0;
                        req_q <= 1'b1;
                        state <= rc_pkg::sweep_fetch;
                    end
                end
                rc_pkg::sweep_fetch: begin
                    if (req_q && mem.ack) begin
                        req_q <= 1'b0;
                    end else if (!req_q && !mem.ack) begin
                        // previous read fully closed
                        if (fetch_addr == LAST_ADDR) begin
                            state <= rc_pkg::sweep_drain;
                        end else begin
                            fetch_addr <= fetch_addr + 1'b1;
                            req_q <= 1'b1;
                        end
                    end
                end
                rc_pkg::sweep_drain: begin
                    if (res_valid && res_addr == LAST_ADDR) begin
                        ray_ack_o <= 1'b1;
                        state <= rc_pkg::sweep_done;
                    end
                end
                rc_pkg::sweep_done: begin
                    if (!ray_req_i) begin
                        ray_ack_o <= 1'b0;
                        state <= rc_pkg::sweep_idle;
                    end
                end
                default: state <= rc_pkg::sweep_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rc_pkg::sweep_idle && ray_req_i) begin
            src_q <= ray_src_i;
            dir_q <= ray_dir_i;
        end
    end

    // strict compare keeps the lower address on equal keys
    always_ff @(posedge clk) begin
        if (rst || (state == rc_pkg::sweep_idle && ray_req_i)) begin
            best_valid <= 1'b0;
            best_addr <= '0;
            best_key <= '0;
        end else if (res_valid && res_hit && (!best_valid || res_key < best_key)) begin
            best_valid <= 1'b1;
            best_addr <= res_addr;
            best_key <= res_key;
        end
    end

    assign mem.req = req_q;
    assign mem.we = 1'b0;
    assign mem.addr = fetch_addr;
    assign mem.wdata = '0;

    assign hit_o = best_valid;
    assign hit_addr_o = best_addr;
    assign hit_key_o = best_key;

endmodule

/* logic/raycast_top.sv */
`timescale 1ns/1ps

module raycast_top (
    input logic clk,
    input logic rst,
    // shape load port
    input logic load_req_i,
    output logic load_ack_o,
    input logic [rc_pkg::ADDR_W-1:0] load_addr_i,
    input rc_pkg::shape_t load_shape_i,
    // ray port
    input logic ray_req_i,
    output logic ray_ack_o,
    input rc_pkg::vec3_t ray_src_i,
    input rc_pkg::vec3_t ray_dir_i,
    output logic hit_o,
    output logic [rc_pkg::ADDR_W-1:0] hit_addr_o,
    output rc_pkg::key_t hit_key_o
);

    shape_mem_if sweep_mem ();
    shape_mem_if load_mem ();

    shape_store u_store (
        .clk(clk),
        .rst(rst),
        .sweep_port(sweep_mem.store),
        .load_port(load_mem.store)
    );

    shape_loader u_loader (
        .clk(clk),
        .rst(rst),
        .load_req_i(load_req_i),
        .load_ack_o(load_ack_o),
        .load_addr_i(load_addr_i),
        .load_shape_i(load_shape_i),
        .mem(load_mem.requester)
    );

    nearest_hit_sweep u_sweep (
        .clk(clk),
        .rst(rst),
        .ray_req_i(ray_req_i),
        .ray_ack_o(ray_ack_o),
        .ray_src_i(ray_src_i),
        .ray_dir_i(ray_dir_i),
        .hit_o(hit_o),
        .hit_addr_o(hit_addr_o),
        .hit_key_o(hit_key_o),
        .mem(sweep_mem.requester)
    );

endmodule

/* logic/rc_pkg.sv */
package rc_pkg;

    // coordinate and table sizes
    localparam int COORD_W = 10;
    localparam int NUM_SHAPES = 8;
    localparam int ADDR_W = $clog2(NUM_SHAPES);

    // arithmetic widths inside the sphere test
    // one difference times one coordinate
    localparam int PROD_W = 22;
    // sum of three products, also the key width
    localparam int DOT_W = 24;
    localparam int DISC_W = 48;

    localparam int TEST_STAGES = 4;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef enum logic {
        shape_off    = 1'b0,
        shape_sphere = 1'b1
    } shape_type_e;

    // shape_type sits in the msb, so an all-zero entry is off
    typedef struct packed {
        shape_type_e shape_type;
        vec3_t centre;
        logic [DOT_W-1:0] radius_sq;
    } shape_t;

    typedef logic signed [DOT_W-1:0] key_t;

    typedef enum logic [1:0] {
        sweep_idle  = 2'd0,
        sweep_fetch = 2'd1,
        sweep_drain = 2'd2,
        sweep_done  = 2'd3
    } sweep_state_e;

endpackage

/* logic/shape_loader.sv */
`timescale 1ns/1ps

module shape_loader (
    input logic clk,
    input logic rst,
    input logic load_req_i,
    output logic load_ack_o,
    input logic [rc_pkg::ADDR_W-1:0] load_addr_i,
    input rc_pkg::shape_t load_shape_i,
    shape_mem_if.requester mem
);

    typedef enum logic [1:0] {
        ld_idle   = 2'd0,
        ld_write  = 2'd1,
        ld_ack    = 2'd2,
        ld_settle = 2'd3
    } load_state_e;

    load_state_e state;
    logic req_q;
    logic [rc_pkg::ADDR_W-1:0] addr_q;
    rc_pkg::shape_t shape_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ld_idle;
            req_q <= 1'b0;
            load_ack_o <= 1'b0;
        end else begin
            case (state)
                ld_idle: begin
                    if (load_req_i) begin
                        req_q <= 1'b1;
                        state <= ld_write;
                    end
                end
                ld_write: begin
                    if (mem.ack) begin
                        req_q <= 1'b0;
                        load_ack_o <= 1'b1;
                        state <= ld_ack;
                    end
                end
                ld_ack: begin
                    if (!load_req_i) begin
                        load_ack_o <= 1'b0;
                        state <= ld_settle;
                    end
                end
                // memory side must be back to idle before the next load
                ld_settle: begin
                    if (!mem.ack) begin
                        state <= ld_idle;
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // payload capture, held for the whole write
    always_ff @(posedge clk) begin
        if (state == ld_idle && load_req_i) begin
            addr_q <= load_addr_i;
            shape_q <= load_shape_i;
        end
    end

    assign mem.req = req_q;
    assign mem.we = 1'b1;
    assign mem.addr = addr_q;
    assign mem.wdata = shape_q;

endmodule

/* logic/shape_mem_if.sv */
`timescale 1ns/1ps

// one requester port of the shape store, four-phase req/ack
interface shape_mem_if;

    logic req;
    logic ack;
    logic we;
    logic [rc_pkg::ADDR_W-1:0] addr;
    rc_pkg::shape_t wdata;
    // valid while ack is high on a read
    rc_pkg::shape_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input ack, rdata
    );

    modport store (
        input req, we, addr, wdata,
        output ack, rdata
    );

endinterface

/* logic/shape_store.sv */
`timescale 1ns/1ps

module shape_store (
    input logic clk,
    input logic rst,
    shape_mem_if.store sweep_port,
    shape_mem_if.store load_port
);

    typedef enum logic [1:0] {
        store_idle  = 2'd0,
        store_grant = 2'd1,
        store_ack   = 2'd2
    } store_state_e;

    store_state_e state;
    // 1 = sweep owns the access, 0 = loader
    logic sel_sweep;

    rc_pkg::shape_t mem [rc_pkg::NUM_SHAPES];
    rc_pkg::shape_t rdata_q;

    // signals of the granted port
    logic cur_req;
    logic cur_we;
    logic [rc_pkg::ADDR_W-1:0] cur_addr;
    rc_pkg::shape_t cur_wdata;

    assign cur_req = sel_sweep ? sweep_port.req : load_port.req;
    assign cur_we = sel_sweep ? sweep_port.we : load_port.we;
    assign cur_addr = sel_sweep ? sweep_port.addr : load_port.addr;
    assign cur_wdata = sel_sweep ? sweep_port.wdata : load_port.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= store_idle;
            sel_sweep <= 1'b0;
            for (int i = 0; i < rc_pkg::NUM_SHAPES; i++) begin
                mem[i].shape_type <= rc_pkg::shape_off;
            end
        end else begin
            case (state)
                store_idle: begin
                    // fixed priority, sweep wins
                    if (sweep_port.req) begin
                        sel_sweep <= 1'b1;
                        state <= store_grant;
                    end else if (load_port.req) begin
                        sel_sweep <= 1'b0;
                        state <= store_grant;
                    end
                end
                store_grant: begin
                    if (cur_we) begin
                        mem[cur_addr] <= cur_wdata;
                    end else begin
                        rdata_q <= mem[cur_addr];
                    end
                    state <= store_ack;
                end
                store_ack: begin
                    if (!cur_req) begin
                        state <= store_idle;
                    end
                end
                default: state <= store_idle;
            endcase
        end
    end

    assign sweep_port.ack = (state == store_ack) && sel_sweep;
    assign load_port.ack = (state == store_ack) && !sel_sweep;
    assign sweep_port.rdata = rdata_q;
    assign load_port.rdata = rdata_q;

endmodule

/* logic/sphere_test.sv */
`timescale 1ns/1ps

module sphere_test (
    input logic clk,
    input logic rst,
    input logic valid_i,
    input logic [rc_pkg::ADDR_W-1:0] addr_i,
    input rc_pkg::vec3_t src_i,
    input rc_pkg::vec3_t dir_i,
    input rc_pkg::shape_t shape_i,
    output logic valid_o,
    output logic [rc_pkg::ADDR_W-1:0] addr_o,
    output logic hit_o,
    output rc_pkg::key_t key_o
);

    // valid and address ride alongside the data
    logic [rc_pkg::TEST_STAGES-1:0] vld;
    logic [rc_pkg::ADDR_W-1:0] addr_pipe [rc_pkg::TEST_STAGES];

    // stage 1: O = S - C, one bit wider than a coordinate
    logic signed [rc_pkg::COORD_W:0] s1_o [3];
    logic signed [rc_pkg::COORD_W-1:0] s1_d [3];
    logic s1_sphere;
    logic [rc_pkg::DOT_W-1:0] s1_r2;

    // stage 2: a = D.D, b = O.D, oo = O.O
    logic signed [rc_pkg::PROD_W-1:0] oo_p [3];
    logic signed [rc_pkg::PROD_W-1:0] od_p [3];
    logic signed [rc_pkg::PROD_W-1:0] dd_p [3];
    logic signed [rc_pkg::DOT_W-1:0] s2_a;
    logic signed [rc_pkg::DOT_W-1:0] s2_b;
    logic signed [rc_pkg::DOT_W-1:0] s2_oo;
    logic s2_sphere;
    logic [rc_pkg::DOT_W-1:0] s2_r2;

    // stage 3: key and the two discriminant terms
    rc_pkg::key_t key_c;
    rc_pkg::key_t s3_key;
    logic signed [rc_pkg::DISC_W-1:0] s3_bb;
    logic signed [rc_pkg::DISC_W-1:0] s3_ac;
    logic s3_bneg;
    logic s3_sphere;

    // stage 4
    logic signed [rc_pkg::DISC_W-1:0] disc_c;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[rc_pkg::TEST_STAGES-2:0], valid_i};
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= addr_i;
        for (int i = 1; i < rc_pkg::TEST_STAGES; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        s1_o[0] <= src_i.x - shape_i.centre.x;
        s1_o[1] <= src_i.y - shape_i.centre.y;
        s1_o[2] <= src_i.z - shape_i.centre.z;
        s1_d[0] <= dir_i.x;
        s1_d[1] <= dir_i.y;
        s1_d[2] <= dir_i.z;
        s1_sphere <= (shape_i.shape_type == rc_pkg::shape_sphere);
        s1_r2 <= shape_i.radius_sq;
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            oo_p[i] = s1_o[i] * s1_o[i];
            od_p[i] = s1_o[i] * s1_d[i];
            dd_p[i] = s1_d[i] * s1_d[i];
        end
    end

    always_ff @(posedge clk) begin
        s2_a <= dd_p[0] + dd_p[1] + dd_p[2];
        s2_b <= od_p[0] + od_p[1] + od_p[2];
        s2_oo <= oo_p[0] + oo_p[1] + oo_p[2];
        s2_sphere <= s1_sphere;
        s2_r2 <= s1_r2;
    end

    // proximity key c = O.O - R2
    assign key_c = s2_oo - $signed(s2_r2);

    always_ff @(posedge clk) begin
        s3_key <= key_c;
        s3_bb <= s2_b * s2_b;
        s3_ac <= s2_a * key_c;
        // ray must point towards the centre
        s3_bneg <= (s2_b < 0);
        s3_sphere <= s2_sphere;
    end

    assign disc_c = s3_bb - s3_ac;

    always_ff @(posedge clk) begin
        hit_o <= s3_sphere && s3_bneg && (disc_c >= 0);
        key_o <= s3_key;
    end

    assign valid_o = vld[rc_pkg::TEST_STAGES-1];
    assign addr_o = addr_pipe[rc_pkg::TEST_STAGES-1];

endmodule
